// ==== testbench/rab_cfg_testdata.txt ====
# op name arg0 arg1 arg2, numbers in hex
# W addr data strb | R addr exp_data 0 | M addr meta exp_full | C index exp_word 0
W virt_ones 20 ffffffffffffffff ff
C virt_cfg 4 00000000ffffffff 0
R virt_rd 20 00000000ffffffff 0
W phys_ones 30 ffffffffffffffff ff
C phys_cfg 6 000000ffffffffff 0
R phys_rd 30 000000ffffffffff 0
W flag_ones 38 ffffffffffffffff ff
C flag_cfg 7 000000000000000f 0
R flag_rd 38 000000000000000f 0
W part_full 50 1122334455667788 ff
W part_strb 50 aabbccddeeff0011 12
C part_cfg a 000000dd55660088 0
R part_rd 50 000000dd55660088 0
R part_hi 54 00000000000000dd 0
M miss1 12345678 0a5 0
M miss2 9abcdef0 15a 0
R pop_a1 0 0000000012345678 0
R pop_m1 8 00000000000000a5 0
R pop_a2 0 000000009abcdef0 0
R pop_m2 8 000000000000015a 0
R meta_empty 8 0000000080000000 0
M fill1 a0000001 001 0
M fill2 a0000002 002 0
M fill3 a0000003 003 0
M fill4 a0000004 004 0
M fill5 a0000005 005 1
R fill_a1 0 00000000a0000001 0
R fill_a2 0 00000000a0000002 0
R fill_a3 0 00000000a0000003 0
R fill_a4 0 00000000a0000004 0
R fill_a5 0 0000000000000000 0
R fill_m1 8 0000000000000001 0
R fill_m2 8 0000000000000002 0
R fill_m3 8 0000000000000003 0
R fill_m4 8 0000000000000004 0
R fill_m5 8 0000000080000000 0
W conf_off c 0000000000000001 ff
M miss_off 55555555 003 0
R off_empty 0 0000000000000000 0
R conf_rd1 c 0000000000000001 0
W conf_mhit c 0000000000000002 ff
R conf_rd2 c 0000000000000002 0
W l2_wr0 4000 ffffffffffffffff ff
W l2_wr1 4028 ffffffffffffffff ff
W l2_wr2 7ff8 ffffffffffffffff ff
C l2_virt 4 00000000ffffffff 0
C l2_phys 6 000000ffffffffff 0
C l2_flag 7 000000000000000f 0
C l2_part a 000000dd55660088 0
C l2_free 8 0000000000000000 0

// ==== tb.f ====
hdl/axi_lite_pkg.sv
hdl/rab_cfg_pkg.sv
hdl/miss_fifo.sv
hdl/axi_lite_slave.sv
hdl/l1_cfg_regs.sv
hdl/miss_handler.sv
hdl/rab_cfg_top.sv
testbench/tb_rab_cfg.sv

// ==== testbench/tb_rab_cfg.sv ====
/*
  Testbench for rab_cfg_top, driven by operations from the test data file.
  Expects N_SLICES 8 and MH_FIFO_DEPTH 4, to match the expected values there.
  Bus inputs change on the falling clock edge and outputs are sampled there.
*/
module tb_rab_cfg
  import axi_lite_pkg::*, rab_cfg_pkg::*;
();

  localparam int unsigned N_SLICES      = 8;
  localparam int unsigned MH_FIFO_DEPTH = 4;
  localparam int unsigned N_REGS        = 4*N_SLICES + 4;
  localparam int unsigned CLK_PERIOD    = 20;
  localparam int unsigned RST_CYCLES    = 4;
  localparam int unsigned OP_TIME       = 200; // time budget of one operation
  localparam int unsigned HS_LIMIT      = 20;  // cycles allowed for one handshake

  logic                       Clk_CI;
  logic                       Rst_RBI;
  axi_lite_req_t              axi_req;
  axi_lite_rsp_t              axi_rsp;
  miss_t                      miss;
  logic                       mh_fifo_full;
  logic                       l1_allow_multi_hit;
  cfg_word_t [4*N_SLICES+3:0] l1_cfg;

  string       op_q[$];
  string       name_q[$];
  logic [63:0] arg0_q[$];
  logic [63:0] arg1_q[$];
  logic [63:0] arg2_q[$];
  int unsigned n_ops;
  bit          ops_loaded;
  int unsigned err_count;
  int unsigned n_failed_tests;
  logic [31:0] rng_q;
  cfg_word_t   shadow [N_REGS];  // slice registers as the writes so far should leave them

  rab_cfg_top #(
    .N_SLICES      (N_SLICES),
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) rab_cfg_top_inst (
    .Clk_CI               (Clk_CI),
    .Rst_RBI              (Rst_RBI),
    .axi_req_i            (axi_req),
    .axi_rsp_o            (axi_rsp),
    .miss_i               (miss),
    .mh_fifo_full_o       (mh_fifo_full),
    .l1_cfg_o             (l1_cfg),
    .l1_allow_multi_hit_o (l1_allow_multi_hit)
  );

  initial
  begin
    Clk_CI = 1'b0;
    forever #(CLK_PERIOD/2) Clk_CI = ~Clk_CI;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // bready and rready wait 0 to 3 cycles
  function automatic int unsigned random_delay();
    rng_q = next_random(rng_q);
    return rng_q % 4;
  endfunction

  // new register value: strobed bytes from data, the rest kept, then cut to the field
  function automatic cfg_word_t expect_write(input int unsigned idx, input cfg_word_t old,
                                             input axi_data_t data, input axi_strb_t strb);
    cfg_word_t keep;
    cfg_word_t field;
    keep = '0;
    for (int b = 0; b < 8; b++)
      keep[8*b +: 8] = {8{~strb[b]}};
    case (idx % 4)
      2:       field = (cfg_word_t'(1) << ADDR_WIDTH_PHYS) - 1;
      3:       field = (cfg_word_t'(1) << N_FLAGS) - 1;
      default: field = (cfg_word_t'(1) << ADDR_WIDTH_VIRT) - 1;
    endcase
    return ((old & keep) | (data & ~keep)) & field;
  endfunction

  task automatic check_data(input string name, input axi_data_t exp, input axi_data_t act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_cfg_word(input string name, input cfg_word_t exp, input cfg_word_t act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp)
    begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  // every slice register against the expected copy
  task automatic check_all_regs(input string name);
    for (int j = 0; j < N_REGS; j++)
      check_cfg_word($sformatf("%s_reg%0d", name, j), shadow[j], l1_cfg[j]);
  endtask

  task automatic load_ops(output bit ok);
    int          fd;
    int          code;
    string       line;
    string       op;
    string       name;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    ok = 1'b0;
    fd = $fopen("testbench/rab_cfg_testdata.txt", "r");
    if (fd != 0)
    begin
      ok = 1'b1;
      while (!$feof(fd))
      begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 2 || line[0] == "#")
          continue;   // blank line or column comment
        code = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
        if (code != 5)
        begin
          $display("malformed test data line skipped: %s", line);
          continue;
        end
        op_q.push_back(op);
        name_q.push_back(name);
        arg0_q.push_back(a);
        arg1_q.push_back(b);
        arg2_q.push_back(c);
      end
      $fclose(fd);
      n_ops = op_q.size();
    end
  endtask

  // AW and W together, then B under a random bready delay
  task automatic axi_write(input string name, input axi_addr_t addr, input axi_data_t data,
                           input axi_strb_t strb);
    logic        aw_hit;
    logic        w_hit;
    logic        aw_done;
    logic        w_done;
    int unsigned cycles;
    aw_done          = 1'b0;
    w_done           = 1'b0;
    cycles           = 0;
    axi_req.aw_addr  = addr;
    axi_req.aw_valid = 1'b1;
    axi_req.w_data   = data;
    axi_req.w_strb   = strb;
    axi_req.w_valid  = 1'b1;
    while (!(aw_done && w_done) && cycles < HS_LIMIT)
    begin
      aw_hit = axi_req.aw_valid && axi_rsp.aw_ready;
      w_hit  = axi_req.w_valid && axi_rsp.w_ready;
      @(negedge Clk_CI);
      cycles++;
      if (aw_hit)
      begin
        axi_req.aw_valid = 1'b0;
        aw_done          = 1'b1;
      end
      if (w_hit)
      begin
        axi_req.w_valid = 1'b0;
        w_done          = 1'b1;
      end
    end
    if (!(aw_done && w_done))
    begin
      $display("%s: the write address or data was never accepted", name);
      err_count++;
      axi_req.aw_valid = 1'b0;
      axi_req.w_valid  = 1'b0;
    end
    else
    begin
      repeat (random_delay()) @(negedge Clk_CI);
      axi_req.b_ready = 1'b1;
      cycles          = 0;
      while (!axi_rsp.b_valid && cycles < HS_LIMIT)
      begin
        @(negedge Clk_CI);
        cycles++;
      end
      if (!axi_rsp.b_valid)
      begin
        $display("%s: no write response arrived", name);
        err_count++;
      end
      else
        check_resp(name, RESP_OKAY, axi_rsp.b_resp);
      @(negedge Clk_CI);  // B handshake took place on the rising edge
      axi_req.b_ready = 1'b0;
    end
  endtask

  task automatic axi_read(input string name, input axi_addr_t addr, input axi_data_t exp);
    logic        ar_hit;
    logic        ar_done;
    int unsigned cycles;
    ar_done          = 1'b0;
    cycles           = 0;
    axi_req.ar_addr  = addr;
    axi_req.ar_valid = 1'b1;
    while (!ar_done && cycles < HS_LIMIT)
    begin
      ar_hit = axi_rsp.ar_ready;
      @(negedge Clk_CI);
      cycles++;
      ar_done = ar_hit;
    end
    axi_req.ar_valid = 1'b0;
    if (!ar_done)
    begin
      $display("%s: the read address was never accepted", name);
      err_count++;
    end
    else
    begin
      repeat (random_delay()) @(negedge Clk_CI);
      axi_req.r_ready = 1'b1;
      cycles          = 0;
      while (!axi_rsp.r_valid && cycles < HS_LIMIT)
      begin
        @(negedge Clk_CI);
        cycles++;
      end
      if (!axi_rsp.r_valid)
      begin
        $display("%s: no read data arrived", name);
        err_count++;
      end
      else
      begin
        check_data(name, exp, axi_rsp.r_data);
        check_resp(name, RESP_OKAY, axi_rsp.r_resp);
      end
      @(negedge Clk_CI);
      axi_req.r_ready = 1'b0;
    end
  endtask

  // one-cycle miss, full flag sampled in the middle of the low phase
  task automatic apply_miss(input string name, input miss_addr_t addr, input miss_meta_t meta,
                            input logic exp_full);
    miss.addr  = addr;
    miss.meta  = meta;
    miss.valid = 1'b1;
    #(CLK_PERIOD/4);
    check_flag(name, exp_full, mh_fifo_full);
    @(negedge Clk_CI);
    miss = '0;
  endtask

  initial
  begin
    bit          ok;
    int unsigned errs_before;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    Rst_RBI        = 1'b0;
    axi_req        = '0;
    miss           = '0;
    err_count      = 0;
    n_failed_tests = 0;
    n_ops          = 0;
    rng_q          = 32'h8c13;
    for (int j = 0; j < N_REGS; j++)
      shadow[j] = '0;  // all slice registers are zero after reset
    load_ops(ok);
    ops_loaded = ok;
    if (!ok)
    begin
      $display("could not open testbench/rab_cfg_testdata.txt");
      $display("TESTS FAILED");
    end
    else
    begin
      repeat (RST_CYCLES) @(posedge Clk_CI);
      @(negedge Clk_CI);
      Rst_RBI = 1'b1;
      for (int i = 0; i < n_ops; i++)
      begin
        errs_before = err_count;
        a = arg0_q[i];
        b = arg1_q[i];
        c = arg2_q[i];
        if (op_q[i] == "W")
        begin
          axi_write(name_q[i], a[31:0], b, c[7:0]);
          if (a >= CFG_AREA_SIZE && a < L2_AREA_BASE && (a >> 3) < N_REGS)
            shadow[a >> 3] = expect_write(a >> 3, shadow[a >> 3], b, c[7:0]);
          check_all_regs(name_q[i]);  // L2 window writes must leave all of them alone
          if (a == OFS_CONF)
            check_flag({name_q[i], "_multi_hit"}, b[1], l1_allow_multi_hit);
        end
        else if (op_q[i] == "R")
          axi_read(name_q[i], a[31:0], b);
        else if (op_q[i] == "M")
          apply_miss(name_q[i], a[31:0], b[MISS_META_WIDTH-1:0], c[0]);
        else if (op_q[i] == "C")
          check_cfg_word(name_q[i], b, l1_cfg[a]);
        else
        begin
          $display("%s: unknown operation %s", name_q[i], op_q[i]);
          err_count++;
        end
        if (err_count == errs_before)
          $display("PASS %s", name_q[i]);
        else
        begin
          $display("FAIL %s", name_q[i]);
          n_failed_tests++;
        end
      end
      $display("%0d tests run, %0d failed, %0d check errors", n_ops, n_failed_tests, err_count);
      if (err_count == 0)
        $display("TESTS PASSED");
      else
        $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog sized from the number of operations
  initial
  begin
    wait (ops_loaded);
    #(n_ops * OP_TIME + RST_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d operations worth of time", n_ops);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== hdl/rab_cfg_top.sv ====
/*
  RAB configuration port, AXI4-Lite with 64-bit data.
  Reads below CFG_AREA_SIZE come from the miss handler, all others from the
  slice registers. Writes at L2_AREA_BASE and above complete without effect.
*/
module rab_cfg_top
  import axi_lite_pkg::*, rab_cfg_pkg::*;
#(
  parameter int unsigned N_SLICES      = 8,
  parameter int unsigned MH_FIFO_DEPTH = 4
)
(
  input  logic                       Clk_CI,
  input  logic                       Rst_RBI,
  input  axi_lite_req_t              axi_req_i,
  output axi_lite_rsp_t              axi_rsp_o,
  input  miss_t                      miss_i,
  output logic                       mh_fifo_full_o,
  output cfg_word_t [4*N_SLICES+3:0] l1_cfg_o,
  output logic                       l1_allow_multi_hit_o
);

  wr_cmd_t   wr_cmd;
  rd_req_t   rd_req;
  logic      rd_pop;
  axi_data_t rd_data;
  axi_data_t l1_rd_data;
  axi_data_t mh_rd_data;

  // read word by address area
  assign rd_data = (rd_req.addr < CFG_AREA_SIZE) ? mh_rd_data : l1_rd_data;

  axi_lite_slave axi_lite_slave_inst (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .axi_req_i (axi_req_i),
    .axi_rsp_o (axi_rsp_o),
    .rd_data_i (rd_data),
    .wr_cmd_o  (wr_cmd),
    .rd_req_o  (rd_req),
    .rd_pop_o  (rd_pop)
  );

  l1_cfg_regs #(
    .N_SLICES (N_SLICES)
  ) l1_cfg_regs_inst (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .wr_cmd_i  (wr_cmd),
    .rd_req_i  (rd_req),
    .l1_cfg_o  (l1_cfg_o),
    .rd_data_o (l1_rd_data)
  );

  miss_handler #(
    .MH_FIFO_DEPTH (MH_FIFO_DEPTH)
  ) miss_handler_inst (
    .Clk_CI               (Clk_CI),
    .Rst_RBI              (Rst_RBI),
    .miss_i               (miss_i),
    .wr_cmd_i             (wr_cmd),
    .rd_req_i             (rd_req),
    .rd_pop_i             (rd_pop),
    .rd_data_o            (mh_rd_data),
    .mh_fifo_full_o       (mh_fifo_full_o),
    .l1_allow_multi_hit_o (l1_allow_multi_hit_o)
  );

endmodule

// ==== hdl/miss_handler.sv ====
/*
  Miss capture into an address FIFO and a metadata FIFO, plus the two-bit
  config register (bit 0 disables both FIFOs, bit 1 allows L1 multi-hit).
  A miss wins over a software push in the same cycle, the push is lost.
*/
module miss_handler
  import axi_lite_pkg::*, rab_cfg_pkg::*;
#(
  parameter int unsigned MH_FIFO_DEPTH = 4
)
(
  input  logic      Clk_CI,
  input  logic      Rst_RBI,
  input  miss_t     miss_i,
  input  wr_cmd_t   wr_cmd_i,
  input  rd_req_t   rd_req_i,
  input  logic      rd_pop_i,
  output axi_data_t rd_data_o,
  output logic      mh_fifo_full_o,
  output logic      l1_allow_multi_hit_o
);

  logic [1:0] conf_q;
  logic       fifos_off;
  logic       miss_ok;
  logic       any_full;
  logic       sw_addr_wr;
  logic       sw_meta_wr;
  logic       rd_sel_addr;
  logic       rd_sel_meta;

  logic       addr_push;
  logic       addr_pop;
  logic       addr_full;
  logic       addr_empty;
  miss_addr_t addr_din;
  miss_addr_t addr_head;

  logic       meta_push;
  logic       meta_pop;
  logic       meta_full;
  logic       meta_empty;
  miss_meta_t meta_din;
  miss_meta_t meta_head;

  assign fifos_off            = conf_q[0];
  assign l1_allow_multi_hit_o = conf_q[1];

  assign miss_ok        = miss_i.valid & ~fifos_off;
  assign any_full       = addr_full | meta_full;
  assign mh_fifo_full_o = miss_ok & any_full;  // this miss is dropped

  assign sw_addr_wr  = wr_cmd_i.en && (wr_cmd_i.addr == OFS_MH_ADDR) && !fifos_off;
  assign sw_meta_wr  = wr_cmd_i.en && (wr_cmd_i.addr == OFS_MH_META) && !fifos_off;
  assign rd_sel_addr = (rd_req_i.addr == OFS_MH_ADDR);
  assign rd_sel_meta = (rd_req_i.addr == OFS_MH_META);

  // push selection, a miss always goes into both FIFOs together
  always_comb
  begin
    addr_push = 1'b0;
    meta_push = 1'b0;
    addr_din  = wr_cmd_i.data[ADDR_WIDTH_VIRT-1:0];
    meta_din  = wr_cmd_i.data[MISS_META_WIDTH-1:0];
    if (miss_ok)
    begin
      addr_push = ~any_full;
      meta_push = ~any_full;
      addr_din  = miss_i.addr;
      meta_din  = miss_i.meta;
    end
    else
    begin
      addr_push = sw_addr_wr & ~addr_full;
      meta_push = sw_meta_wr & ~meta_full;
    end
  end

  assign addr_pop = rd_pop_i & rd_sel_addr & ~addr_empty;
  assign meta_pop = rd_pop_i & rd_sel_meta & ~meta_empty;

  always_comb
  begin
    rd_data_o = '0;
    if (rd_sel_addr)
    begin
      if (!addr_empty)
        rd_data_o[ADDR_WIDTH_VIRT-1:0] = addr_head;
    end
    else if (rd_sel_meta)
    begin
      rd_data_o[31] = meta_empty;
      if (!meta_empty)
        rd_data_o[MISS_META_WIDTH-1:0] = meta_head;
    end
    else if (rd_req_i.addr == OFS_CONF)
      rd_data_o[1:0] = conf_q;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      conf_q <= 2'b00;
    else if (wr_cmd_i.en && (wr_cmd_i.addr == OFS_CONF))
      conf_q <= wr_cmd_i.data[1:0];
  end

  miss_fifo #(
    .payload_t (miss_addr_t),
    .DEPTH     (MH_FIFO_DEPTH)
  ) addr_fifo_inst (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .pop_i   (addr_pop),
    .data_o  (addr_head),
    .full_o  (addr_full),
    .empty_o (addr_empty)
  );

  miss_fifo #(
    .payload_t (miss_meta_t),
    .DEPTH     (MH_FIFO_DEPTH)
  ) meta_fifo_inst (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (meta_push),
    .data_i  (meta_din),
    .pop_i   (meta_pop),
    .data_o  (meta_head),
    .full_o  (meta_full),
    .empty_o (meta_empty)
  );

endmodule

// ==== hdl/l1_cfg_regs.sv ====
/*
  L1 slice registers, four words per slice plus the control area words.
  Stored bits outside a field stay zero. Software must keep writes inside
  the slice range, indices past the last slice are not backed by storage.
*/
module l1_cfg_regs
  import axi_lite_pkg::*, rab_cfg_pkg::*;
#(
  parameter int unsigned N_SLICES = 8
)
(
  input  logic                          Clk_CI,
  input  logic                          Rst_RBI,
  input  wr_cmd_t                       wr_cmd_i,
  input  rd_req_t                       rd_req_i,
  output cfg_word_t [4*N_SLICES+3:0]    l1_cfg_o,
  output axi_data_t                     rd_data_o
);

  localparam int unsigned N_REGS = 4*N_SLICES + 4;
  localparam int unsigned IDX_W  = $clog2(N_REGS);

  logic             wr_en;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  cfg_word_t        wr_mask;
  cfg_word_t        rd_word;

  // bit 1 clear: virtual address, 2'b10: physical address, 2'b11: flags
  function automatic cfg_word_t field_mask(input logic [1:0] kind);
    if (!kind[1])
      return cfg_word_t'({ADDR_WIDTH_VIRT{1'b1}});
    if (!kind[0])
      return cfg_word_t'({ADDR_WIDTH_PHYS{1'b1}});
    return cfg_word_t'({N_FLAGS{1'b1}});
  endfunction

  assign wr_en   = wr_cmd_i.en && (wr_cmd_i.addr >= CFG_AREA_SIZE)
                   && (wr_cmd_i.addr < L2_AREA_BASE);
  assign wr_idx  = wr_cmd_i.addr[3 +: IDX_W];
  assign rd_idx  = rd_req_i.addr[3 +: IDX_W];
  assign wr_mask = field_mask(wr_idx[1:0]);

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      l1_cfg_o <= '0;
    else if (wr_en)
    begin
      for (int b = 0; b < 8; b++)
      begin
        if (wr_mask[8*b +: 8] != 8'h00)
        begin
          if (wr_cmd_i.strb[b])
            l1_cfg_o[wr_idx][8*b +: 8] <= wr_cmd_i.data[8*b +: 8] & wr_mask[8*b +: 8];
        end
        else
          l1_cfg_o[wr_idx][8*b +: 8] <= 8'h00;  // byte lies outside the field
      end
    end
  end

  always_comb
  begin
    rd_word = '0;
    if ((rd_req_i.addr >> 3) < N_REGS)
      rd_word = l1_cfg_o[rd_idx];
    if (rd_req_i.addr[2])
      rd_data_o = {32'h0000_0000, rd_word[63:32]};  // debug view for 32-bit hosts
    else
      rd_data_o = rd_word;
  end

  a_wr_in_range : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_en |-> ((wr_cmd_i.addr >> 3) < N_REGS))
    else $error("slice write beyond the last register");

endmodule

// ==== hdl/axi_lite_slave.sv ====
/*
  AXI4-Lite slave front end, one write and one read in flight at most.
  Responses are always OKAY. rdata is held from the first rvalid cycle
  until the R handshake, so late register changes are not seen by the bus.
*/
module axi_lite_slave
  import axi_lite_pkg::*, rab_cfg_pkg::*;
(
  input  logic          Clk_CI,
  input  logic          Rst_RBI,
  input  axi_lite_req_t axi_req_i,
  output axi_lite_rsp_t axi_rsp_o,
  input  axi_data_t     rd_data_i,
  output wr_cmd_t       wr_cmd_o,
  output rd_req_t       rd_req_o,
  output logic          rd_pop_o
);

  logic      aw_ready_q;
  logic      w_ready_q;
  logic      wr_en_q;
  logic      b_valid_q;
  logic      r_valid_q;
  logic      r_hold_q;

  axi_addr_t aw_addr_q;
  axi_data_t w_data_q;
  axi_strb_t w_strb_q;
  axi_addr_t ar_addr_q;
  axi_data_t r_data_q;

  logic      aw_hs;
  logic      w_hs;
  logic      b_hs;
  logic      ar_hs;
  logic      r_hs;

  assign aw_hs = aw_ready_q & axi_req_i.aw_valid;
  assign w_hs  = w_ready_q & axi_req_i.w_valid;
  assign b_hs  = b_valid_q & axi_req_i.b_ready;
  assign ar_hs = ~r_valid_q & axi_req_i.ar_valid; // arready is the inverse of rvalid
  assign r_hs  = r_valid_q & axi_req_i.r_ready;

  // payload capture, no reset needed
  always_ff @(posedge Clk_CI)
  begin
    if (aw_hs)
      aw_addr_q <= axi_req_i.aw_addr;
    if (w_hs)
    begin
      w_data_q <= axi_req_i.w_data;
      w_strb_q <= axi_req_i.w_strb;
    end
    if (ar_hs)
      ar_addr_q <= axi_req_i.ar_addr;
    if (r_valid_q && !r_hold_q)
      r_data_q <= rd_data_i;  // freeze the word seen in the first rvalid cycle
  end

  // write side: AW and W in any order, then one enable, then B
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      aw_ready_q <= 1'b1;
      w_ready_q  <= 1'b1;
      wr_en_q    <= 1'b0;
      b_valid_q  <= 1'b0;
    end
    else
    begin
      if (aw_hs)
        aw_ready_q <= 1'b0;
      else if (b_hs)
        aw_ready_q <= 1'b1;

      if (w_hs)
        w_ready_q <= 1'b0;
      else if (b_hs)
        w_ready_q <= 1'b1;

      // fires on the later of the two acceptances only
      wr_en_q <= (aw_hs || !aw_ready_q) && (w_hs || !w_ready_q) && (aw_ready_q || w_ready_q);

      if (wr_en_q)
        b_valid_q <= 1'b1;
      else if (b_hs)
        b_valid_q <= 1'b0;
    end
  end

  // read side
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      r_valid_q <= 1'b0;
      r_hold_q  <= 1'b0;
    end
    else
    begin
      if (ar_hs)
        r_valid_q <= 1'b1;
      else if (r_hs)
        r_valid_q <= 1'b0;

      if (r_hs)
        r_hold_q <= 1'b0;
      else if (r_valid_q)
        r_hold_q <= 1'b1;
    end
  end

  always_comb
  begin
    axi_rsp_o          = '0;
    axi_rsp_o.aw_ready = aw_ready_q;
    axi_rsp_o.w_ready  = w_ready_q;
    axi_rsp_o.b_resp   = RESP_OKAY;
    axi_rsp_o.b_valid  = b_valid_q;
    axi_rsp_o.ar_ready = ~r_valid_q;
    axi_rsp_o.r_data   = r_hold_q ? r_data_q : rd_data_i;
    axi_rsp_o.r_resp   = RESP_OKAY;
    axi_rsp_o.r_valid  = r_valid_q;
  end

  always_comb
  begin
    wr_cmd_o.addr = aw_addr_q;
    wr_cmd_o.data = w_data_q;
    wr_cmd_o.strb = w_strb_q;
    wr_cmd_o.en   = wr_en_q;
  end

  assign rd_req_o.addr = ar_addr_q;
  assign rd_pop_o      = r_hs;  // FIFO heads only leave on a completed read

  // every enable gets its own B, none is committed while one is pending
  a_b_after_write : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    wr_en_q |-> !b_valid_q)
    else $error("write committed while a response is still pending");

  a_rdata_stable : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (axi_rsp_o.r_valid && !axi_req_i.r_ready) |=> $stable(axi_rsp_o.r_data))
    else $error("rdata changed during a stalled read");

endmodule

// ==== hdl/miss_fifo.sv ====
/*
  Small FIFO for one miss payload. A push when full and a pop when empty
  are ignored. data_o is undefined while empty_o is high.
*/
module miss_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
)
(
  input  logic     Clk_CI,
  input  logic     Rst_RBI,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;
  logic             pop_ok;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge Clk_CI)
  begin
    if (push_ok)
      mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_ok)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_ok)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push_ok && !pop_ok)
        count_q <= count_q + 1'b1;
      else if (pop_ok && !push_ok)
        count_q <= count_q - 1'b1;
    end
  end

  // the owner is expected to gate pushes with full_o
  a_no_push_full : assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    push_i |-> !full_o)
    else $error("push while FIFO full");

endmodule

// ==== hdl/rab_cfg_pkg.sv ====
/*
  RAB configuration map and miss record types.
  Offsets below CFG_AREA_SIZE are the control area, slices start there.
  Addresses from L2_AREA_BASE upwards are accepted but have no target.
*/
package rab_cfg_pkg;

  // field widths of one slice
  localparam int unsigned ADDR_WIDTH_VIRT = 32;
  localparam int unsigned ADDR_WIDTH_PHYS = 40;
  localparam int unsigned N_FLAGS         = 4;
  localparam int unsigned MISS_META_WIDTH = 10;

  localparam int unsigned CFG_AREA_SIZE = 'h20;   // end of the control area
  localparam int unsigned L2_AREA_BASE  = 'h4000; // no L2 behind this window

  // control area offsets
  localparam int unsigned OFS_MH_ADDR = 'h00;
  localparam int unsigned OFS_MH_META = 'h08;
  localparam int unsigned OFS_CONF    = 'h0C;

  typedef logic [63:0] cfg_word_t;

  typedef logic [ADDR_WIDTH_VIRT-1:0] miss_addr_t;
  typedef logic [MISS_META_WIDTH-1:0] miss_meta_t;

  typedef struct packed {
    miss_addr_t addr;
    miss_meta_t meta;
    logic       valid;
  } miss_t;

  // one accepted write, en is high for a single cycle
  typedef struct packed {
    axi_lite_pkg::axi_addr_t addr;
    axi_lite_pkg::axi_data_t data;
    axi_lite_pkg::axi_strb_t strb;
    logic                    en;
  } wr_cmd_t;

  typedef struct packed {
    axi_lite_pkg::axi_addr_t addr;
  } rd_req_t;

endpackage

// ==== hdl/axi_lite_pkg.sv ====
/*
  AXI4-Lite channel bundles for a 32-bit address, 64-bit data slave.
  Only the signals used by the RAB configuration port are carried (no prot).
*/
package axi_lite_pkg;

  localparam int unsigned AXI_ADDR_WIDTH = 32;
  localparam int unsigned AXI_DATA_WIDTH = 64;

  typedef logic [AXI_ADDR_WIDTH-1:0]   axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0]   axi_data_t;
  typedef logic [AXI_DATA_WIDTH/8-1:0] axi_strb_t;
  typedef logic [1:0]                  axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // manager side of all five channels
  typedef struct packed {
    axi_addr_t aw_addr;
    logic      aw_valid;
    axi_data_t w_data;
    axi_strb_t w_strb;
    logic      w_valid;
    logic      b_ready;
    axi_addr_t ar_addr;
    logic      ar_valid;
    logic      r_ready;
  } axi_lite_req_t;

  // slave side of all five channels
  typedef struct packed {
    logic      aw_ready;
    logic      w_ready;
    axi_resp_t b_resp;
    logic      b_valid;
    logic      ar_ready;
    axi_data_t r_data;
    axi_resp_t r_resp;
    logic      r_valid;
  } axi_lite_rsp_t;

endpackage
